// File: hdl/coreParams.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// word width, shared by data and instructions
`define DATA_W 16

// register file geometry
`define NUM_REGS 16
`define REG_ADDR_W 4

// wishbone address map
`define ADR_W 5
`define PSR_ADR 5'h10 // read gives psr, write executes

`endif

// File: hdl/corePkg.sv
`include "coreParams.svh"

package corePkg;

	// alu operation codes, shared by both instruction forms
	typedef enum logic [3:0] {
		opNop  = 4'd0,
		opAnd  = 4'd1,
		opOr   = 4'd2,
		opXor  = 4'd3,
		opAdd  = 4'd5,
		opAddu = 4'd6,
		opLsh  = 4'd8,
		opSub  = 4'd9,
		opCmp  = 4'd11,
		opMov  = 4'd13
	} aluOp_e;

	// register form, opcode field is zero
	typedef struct packed {
		logic [3:0] opcode;
		logic [`REG_ADDR_W-1:0] dest;
		logic [3:0] ext; // operation code lives here
		logic [`REG_ADDR_W-1:0] src;
	} regForm_t;

	// immediate form, opcode field carries the operation
	typedef struct packed {
		logic [3:0] opcode;
		logic [`REG_ADDR_W-1:0] dest;
		logic [7:0] imm; // signed
	} immForm_t;

	typedef union packed {
		regForm_t regForm;
		immForm_t immForm;
	} instrWord_u;

	// condition flags
	typedef struct packed {
		logic c; // carry or borrow
		logic l; // unsigned less
		logic f; // signed overflow
		logic z; // zero or equal
		logic n; // signed less
	} psr_t;

	typedef struct packed {
		aluOp_e op;
		logic [`REG_ADDR_W-1:0] dest;
		logic [`REG_ADDR_W-1:0] src;
		logic useImm;
		logic [`DATA_W-1:0] immValue; // already sign-extended
	} aluCtrl_t;

endpackage

// File: hdl/instrDecoder.sv
`include "coreParams.svh"

module instrDecoder import corePkg::*; (
	input instrWord_u instr,
	output aluCtrl_t ctrl
);

	logic isRegForm;

	// anything outside the operation table becomes a no-op
	function automatic aluOp_e mapOp(input logic [3:0] code);
		aluOp_e op;
		case (code)
			opAnd, opOr, opXor, opAdd, opAddu, opLsh, opSub, opCmp, opMov: begin
				op = aluOp_e'(code);
			end
			default: begin
				op = opNop;
			end
		endcase
		return op;
	endfunction

	assign isRegForm = (instr.regForm.opcode == 4'd0);

	always_comb begin
		// dest sits in the same bits for both forms
		ctrl.dest = instr.regForm.dest;
		ctrl.src = instr.regForm.src; // ignored by the alu for immediates
		ctrl.immValue = {{(`DATA_W-8){instr.immForm.imm[7]}}, instr.immForm.imm};
		if (isRegForm) begin
			ctrl.op = mapOp(instr.regForm.ext);
			ctrl.useImm = 1'b0;
		end else begin
			ctrl.op = mapOp(instr.immForm.opcode);
			ctrl.useImm = 1'b1;
		end
	end

endmodule

// File: hdl/registerFile.sv
`include "coreParams.svh"

module registerFile (
	input logic clk,
	input logic arstN,
	input logic wrEn,
	input logic [`REG_ADDR_W-1:0] wrAddr,
	input logic [`DATA_W-1:0] wrData,
	input logic [`REG_ADDR_W-1:0] rdAddr1,
	input logic [`REG_ADDR_W-1:0] rdAddr2,
	output logic [`DATA_W-1:0] rdData1,
	output logic [`DATA_W-1:0] rdData2
);

	logic [`DATA_W-1:0] regs [`NUM_REGS];

	// single write port, owned by the sequencer
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// reads are combinational
	assign rdData1 = regs[rdAddr1];
	assign rdData2 = regs[rdAddr2];

endmodule

// File: hdl/alu.sv
`include "coreParams.svh"

module alu import corePkg::*; (
	input aluCtrl_t ctrl,
	input logic [`DATA_W-1:0] opA, // dest register
	input logic [`DATA_W-1:0] opB, // src register
	input psr_t psrIn,
	output logic [`DATA_W-1:0] result,
	output psr_t psrOut,
	output logic writesBack
);

	logic [`DATA_W-1:0] b;
	logic [`DATA_W:0] sum;
	logic [`DATA_W:0] diff;
	logic addOvf;
	logic subOvf;
	logic [4:0] shAmt;
	logic [4:0] shRight;
	logic [`DATA_W-1:0] shifted;

	assign b = ctrl.useImm ? ctrl.immValue : opB;

	assign sum = {1'b0, opA} + {1'b0, b};
	assign diff = {1'b0, opA} - {1'b0, b}; // top bit is the borrow

	// operands agree in sign but the result does not
	assign addOvf = (opA[`DATA_W-1] == b[`DATA_W-1]) &&
		(sum[`DATA_W-1] != opA[`DATA_W-1]);
	assign subOvf = (opA[`DATA_W-1] != b[`DATA_W-1]) &&
		(diff[`DATA_W-1] != opA[`DATA_W-1]);

	// two's complement amount, bit 4 gives the direction
	assign shAmt = b[4:0];
	assign shRight = -shAmt; // 1 to 16
	assign shifted = shAmt[4] ? (opA >> shRight) : (opA << shAmt[3:0]);

	always_comb begin
		result = opA;
		psrOut = '0; // undefined flags read as zero
		writesBack = 1'b1;
		case (ctrl.op)
			opAnd: result = opA & b;
			opOr: result = opA | b;
			opXor: result = opA ^ b;
			opMov: result = b;
			opAddu: result = sum[`DATA_W-1:0];
			opLsh: result = shifted;
			opAdd: begin
				result = sum[`DATA_W-1:0];
				psrOut.c = sum[`DATA_W];
				psrOut.f = addOvf;
			end
			opSub: begin
				result = diff[`DATA_W-1:0];
				psrOut.c = diff[`DATA_W];
				psrOut.f = subOvf;
			end
			opCmp: begin
				result = diff[`DATA_W-1:0];
				writesBack = 1'b0;
				psrOut.z = (opA == b);
				psrOut.l = diff[`DATA_W];
				psrOut.n = ($signed(opA) < $signed(b));
			end
			default: begin
				writesBack = 1'b0;
				psrOut = psrIn; // no-op keeps the flags
			end
		endcase
		// every writing op reports a zero result
		if (writesBack) begin
			psrOut.z = (result == '0);
		end
	end

endmodule

// File: hdl/execSequencer.sv
`include "coreParams.svh"

module execSequencer import corePkg::*; (
	input logic clk,
	input logic arstN,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [`ADR_W-1:0] adr,
	input logic [`DATA_W-1:0] datIn,
	input logic [`DATA_W-1:0] rdData1,
	input logic [`DATA_W-1:0] aluResult,
	input psr_t aluPsr,
	input aluCtrl_t ctrl,
	output logic [`DATA_W-1:0] datOut,
	output logic ack,
	output instrWord_u instr,
	output logic [`REG_ADDR_W-1:0] rdAddr1,
	output logic [`REG_ADDR_W-1:0] rdAddr2,
	output logic wrEn,
	output logic [`REG_ADDR_W-1:0] wrAddr,
	output logic [`DATA_W-1:0] wrData,
	output psr_t psr
);

	typedef enum logic [1:0] {
		stIdle,
		stExec,
		stAck
	} state_e;

	state_e state;
	logic req;
	logic isReg;
	logic isPsr;
	logic hostLoad;
	logic execWrite;
	logic [`DATA_W-1:0] psrWord;

	// a new cycle is only taken from idle
	assign req = cyc && stb && (state == stIdle);
	assign isReg = (adr[`ADR_W-1:`REG_ADDR_W] == '0);
	assign isPsr = (adr == `PSR_ADR);
	assign psrWord = {{(`DATA_W-$bits(psr_t)){1'b0}}, psr};

	// write port arbitration, host load or alu writeback
	assign hostLoad = req && we && isReg;
	assign execWrite = (state == stExec) && (ctrl.op != opCmp) && (ctrl.op != opNop);
	assign wrEn = hostLoad || execWrite;
	assign wrAddr = (state == stExec) ? ctrl.dest : adr[`REG_ADDR_W-1:0];
	assign wrData = (state == stExec) ? aluResult : datIn;

	// port 1 serves host reads outside execution
	assign rdAddr1 = (state == stExec) ? ctrl.dest : adr[`REG_ADDR_W-1:0];
	assign rdAddr2 = ctrl.src;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= stIdle;
			ack <= 1'b0;
			psr <= '0;
		end else begin
			ack <= 1'b0; // single cycle pulse
			case (state)
				stIdle: begin
					if (req) begin
						if (we && isPsr) begin
							state <= stExec;
						end else begin
							ack <= 1'b1;
							state <= stAck;
						end
					end
				end
				stExec: begin
					psr <= aluPsr; // no-op hands back the old value
					ack <= 1'b1;
					state <= stAck;
				end
				stAck: state <= stIdle; // stb is gone by now
				default: state <= stIdle;
			endcase
		end
	end

	// instruction word and read data
	always_ff @(posedge clk) begin
		if (req && we && isPsr) begin
			instr <= datIn;
		end
		if (req && !we) begin
			if (isPsr) begin
				datOut <= psrWord;
			end else begin
				datOut <= isReg ? rdData1 : '0; // unmapped reads give zero
			end
		end
	end

endmodule

// File: hdl/coreTop.sv
`include "coreParams.svh"

module coreTop import corePkg::*; (
	input logic clk,
	input logic arstN,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [`ADR_W-1:0] adr,
	input logic [`DATA_W-1:0] datIn,
	output logic [`DATA_W-1:0] datOut,
	output logic ack
);

	instrWord_u instr;
	aluCtrl_t ctrl;
	psr_t psr;
	psr_t aluPsr;
	logic [`REG_ADDR_W-1:0] rdAddr1;
	logic [`REG_ADDR_W-1:0] rdAddr2;
	logic [`REG_ADDR_W-1:0] wrAddr;
	logic [`DATA_W-1:0] rdData1;
	logic [`DATA_W-1:0] rdData2;
	logic [`DATA_W-1:0] wrData;
	logic [`DATA_W-1:0] aluResult;
	logic wrEn;

	execSequencer uSeq (
		.clk(clk), .arstN(arstN), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.datIn(datIn), .rdData1(rdData1), .aluResult(aluResult), .aluPsr(aluPsr),
		.ctrl(ctrl), .datOut(datOut), .ack(ack), .instr(instr),
		.rdAddr1(rdAddr1), .rdAddr2(rdAddr2), .wrEn(wrEn), .wrAddr(wrAddr),
		.wrData(wrData), .psr(psr)
	);

	instrDecoder uDec (.instr(instr), .ctrl(ctrl));

	registerFile uRegs (
		.clk(clk), .arstN(arstN), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.rdAddr1(rdAddr1), .rdAddr2(rdAddr2), .rdData1(rdData1), .rdData2(rdData2)
	);

	// writeback decision is taken by the sequencer from ctrl.op
	alu uAlu (
		.ctrl(ctrl), .opA(rdData1), .opB(rdData2), .psrIn(psr),
		.result(aluResult), .psrOut(aluPsr), .writesBack()
	);

endmodule

// File: tests/coreTb.sv
`include "coreParams.svh"

module coreTb import corePkg::*; ();

	logic clk;
	logic arstN;
	logic cyc;
	logic stb;
	logic we;
	logic [`ADR_W-1:0] adr;
	logic [`DATA_W-1:0] datIn;
	logic [`DATA_W-1:0] datOut;
	logic ack;

	// golden transactions in file order
	logic [7:0] kinds [$];
	logic [`ADR_W-1:0] adrs [$];
	logic [`DATA_W-1:0] datas [$];
	logic [`DATA_W-1:0] expects [$];
	logic loaded = 1'b0;
	logic [15:0] lfsr;

	coreTop DUT (
		.clk(clk), .arstN(arstN), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.datIn(datIn), .datOut(datOut), .ack(ack)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// run length follows the number of transactions
	initial begin
		wait (loaded);
		repeat (kinds.size() * 20 + 200) @(posedge clk);
		$display("ERROR: watchdog expired before all transactions were replayed");
		$display("Something failed");
		$fatal(1, "watchdog");
	end

	// galois form with taps 16 14 13 11
	function automatic logic [15:0] nextLfsr(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end
		return s >> 1;
	endfunction

	task automatic idleGap();
		int gap;
		gap = 0;
		repeat (2) begin
			gap = gap * 2 + int'(lfsr[0]); // one step per bit
			lfsr = nextLfsr(lfsr);
		end
		repeat (gap) @(negedge clk);
	endtask

	task automatic checkAck(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected 0x%h, got 0x%h", name, expected, actual);
			$display("Something failed");
			$fatal(1, "ack mismatch");
		end
	endtask

	task automatic checkCycles(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("FAIL %s: expected 0x%h, got 0x%h", name, expected, actual);
			$display("Something failed");
			$fatal(1, "latency mismatch");
		end
	endtask

	task automatic waitAck(input int latency);
		int n;
		n = 0;
		do begin
			@(negedge clk); // ack and datOut are settled here
			n++;
		end while (!ack && n < 8);
		if (!ack) begin
			$display("ERROR: the DUT did not acknowledge within 8 cycles");
			$display("Something failed");
			$fatal(1, "bus timeout");
		end
		checkCycles("ack latency", latency, n);
	endtask

	task automatic wbWrite(input logic [`ADR_W-1:0] a, input logic [`DATA_W-1:0] d);
		@(negedge clk);
		checkAck("ack before request", 1'b0, ack); // previous pulse is over
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		adr = a;
		datIn = d;
		waitAck((a == `PSR_ADR) ? 2 : 1); // execute needs a second edge
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		idleGap();
	endtask

	task automatic wbRead(input logic [`ADR_W-1:0] a, output logic [`DATA_W-1:0] d);
		@(negedge clk);
		checkAck("ack before request", 1'b0, ack);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b0;
		adr = a;
		waitAck(1);
		d = datOut;
		cyc = 1'b0;
		stb = 1'b0;
		idleGap();
	endtask

	task automatic checkWord(input string name, input logic [`DATA_W-1:0] expected,
		input logic [`DATA_W-1:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected 0x%h, got 0x%h", name, expected, actual);
			$display("Something failed");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic checkPsr(input string name, input psr_t expected, input psr_t actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected 0x%h, got 0x%h", name, expected, actual);
			$display("Something failed");
			$fatal(1, "psr mismatch");
		end
	endtask

	task automatic loadGolden();
		int fd;
		int fields;
		string line;
		logic [7:0] k;
		logic [`ADR_W-1:0] a;
		logic [`DATA_W-1:0] d;
		logic [`DATA_W-1:0] e;
		fd = $fopen("tests/core_golden.txt", "r");
		if (fd == 0) begin
			$display("ERROR: cannot open tests/core_golden.txt");
			$display("Something failed");
			$fatal(1, "missing golden file");
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue; // blank or comment
			end
			fields = $sscanf(line, "%c %h %h %h", k, a, d, e);
			if (fields != 4) begin
				$display("ERROR: malformed line in the golden file: %s", line);
				$display("Something failed");
				$fatal(1, "bad golden line");
			end
			kinds.push_back(k);
			adrs.push_back(a);
			datas.push_back(d);
			expects.push_back(e);
		end
		$fclose(fd);
	endtask

	initial begin
		logic [`DATA_W-1:0] rd;
		logic [`ADR_W-1:0] regAdr;
		arstN = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datIn = '0;
		lfsr = 16'd42;
		loadGolden();
		loaded = 1'b1;
		repeat (10) @(negedge clk);
		arstN = 1'b1;

		// registers and psr come out of reset cleared
		for (int r = 0; r < `NUM_REGS; r++) begin
			regAdr = r[`ADR_W-1:0];
			wbRead(regAdr, rd);
			checkWord($sformatf("datOut r%0d after reset", r), '0, rd);
		end
		wbRead(`PSR_ADR, rd);
		checkPsr("psr after reset", '0, psr_t'(rd[4:0]));

		for (int i = 0; i < kinds.size(); i++) begin
			case (kinds[i])
				"L", "X": wbWrite(adrs[i], datas[i]); // load or execute
				"R": begin
					wbRead(adrs[i], rd);
					checkWord($sformatf("datOut r%0d, item %0d", adrs[i], i), expects[i], rd);
				end
				"P": begin
					wbRead(`PSR_ADR, rd);
					checkPsr($sformatf("psr, item %0d", i), psr_t'(expects[i][4:0]),
						psr_t'(rd[4:0]));
					// bits above the flags read as zero
					checkWord($sformatf("datOut psr word, item %0d", i),
						{{(`DATA_W-5){1'b0}}, expects[i][4:0]}, rd);
				end
				default: begin
					$display("ERROR: unknown transaction kind in item %0d", i);
					$display("Something failed");
					$fatal(1, "bad kind");
				end
			endcase
		end

		$display("Everything OK");
		$finish;
	end

endmodule

// File: tests/core_golden.txt
# kind adr data expected, all hex; L load, R read register, P read psr, X execute
# expected is compared for R and P only; psr bits are c l f z n from bit 4 down
L 01 a5c3 0000
R 01 0000 a5c3
L 02 0ff0 0000
X 10 0112 0000
R 01 0000 05c0
P 10 0000 0000
X 10 0221 0000
R 02 0000 0ff0
X 10 0232 0000
R 02 0000 0000
P 10 0000 0002
X 10 04d1 0000
R 04 0000 05c0
P 10 0000 0000
L 05 7fff 0000
L 06 0001 0000
X 10 0556 0000
R 05 0000 8000
P 10 0000 0004
L 07 ffff 0000
X 10 0756 0000
R 07 0000 0000
P 10 0000 0012
X 10 0796 0000
R 07 0000 ffff
P 10 0000 0010
X 10 0766 0000
R 07 0000 0000
P 10 0000 0002
X 10 54ff 0000
R 04 0000 05bf
P 10 0000 0010
X 10 8604 0000
R 06 0000 0010
X 10 84fc 0000
R 04 0000 005b
X 10 b610 0000
P 10 0000 0002
X 10 b6ff 0000
P 10 0000 0008
X 10 05b6 0000
R 05 0000 8000
P 10 0000 0001
X 10 4612 0000
P 10 0000 0001
X 10 0677 0000
R 06 0000 0010
P 10 0000 0001

// File: all.f
+incdir+hdl
hdl/corePkg.sv
hdl/instrDecoder.sv
hdl/registerFile.sv
hdl/alu.sv
hdl/execSequencer.sv
hdl/coreTop.sv
tests/coreTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module coreTb -f all.f -o coreSim

output=$(./obj_dir/coreSim || true)
echo "$output"

if echo "$output" | grep -qx "Everything OK"; then
	exit 0
else
	exit 1
fi
